// File: Makefile
TOP = tb_mhp

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f files.f

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) -f files.f \
		-o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log

// File: files.f
mhp_pkg.sv
frame_buffer.sv
frame_timer.sv
frame_rx.sv
header_parser.sv
reply_writer.sv
frame_tx.sv
protocol_fsm.sv
mhp_top.sv
tb_clock.sv
tb_mhp.sv

// File: frame_buffer.sv
`default_nettype none

module frame_buffer (
  input  logic              i_clk,
  input  logic              i_rst,
  input  mhp_pkg::mem_req_t i_rx_req,
  input  mhp_pkg::mem_req_t i_parse_req,
  input  mhp_pkg::mem_req_t i_write_req,
  input  mhp_pkg::mem_req_t i_tx_req,
  output logic [7:0]        o_rdata
);
  import mhp_pkg::*;

  logic [7:0] mem [2**BUF_AW];
  mem_req_t   req;

  // only one client is busy at a time, idle ones drive zeros
  assign req = i_rx_req | i_parse_req | i_write_req | i_tx_req;

  always_ff @(posedge i_clk) begin
    if (req.we) begin
      mem[req.addr] <= req.wdata;
    end
  end

  // read data one cycle after the address
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_rdata <= 8'h00;
    end else begin
      o_rdata <= mem[req.addr];
    end
  end

endmodule

`default_nettype wire

// File: frame_rx.sv
`default_nettype none

module frame_rx (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_start,
  input  logic               i_stop,
  input  logic               i_rready,
  input  logic [7:0]         i_rdata,
  output logic               o_rreq,
  output logic               o_byte_seen,
  output mhp_pkg::mem_req_t  o_mem_req,
  output mhp_pkg::buf_addr_t o_len
);
  import mhp_pkg::*;

  logic      active;
  logic      rd_valid;  // fifo byte on i_rdata this cycle
  logic      full;
  buf_addr_t len;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      active      <= 1'b0;
      rd_valid    <= 1'b0;
      full        <= 1'b0;
      len         <= '0;
      o_rreq      <= 1'b0;
      o_byte_seen <= 1'b0;
      o_mem_req   <= '0;
    end else begin
      rd_valid    <= o_rreq;
      o_rreq      <= 1'b0;
      o_byte_seen <= 1'b0;
      o_mem_req   <= '0;

      if (i_start) begin
        active <= 1'b1;
        len    <= '0;
        full   <= 1'b0;
      end else if (i_stop) begin
        active <= 1'b0;
      end

      // never two requests back to back
      if (active && !i_stop && i_rready && !o_rreq) begin
        o_rreq <= 1'b1;
      end

      if (rd_valid) begin
        o_byte_seen <= 1'b1;
        // past the last address the byte is read and dropped
        if (!full) begin
          o_mem_req <= '{we: 1'b1, addr: len, wdata: i_rdata};
          if (len == '1) begin
            full <= 1'b1;
          end else begin
            len <= len + 1'b1;
          end
        end
      end
    end
  end

  assign o_len = len;

endmodule

`default_nettype wire

// File: frame_timer.sv
`default_nettype none

module frame_timer #(
  parameter int IDLE_LIMIT  = 63,
  parameter int PACE_PERIOD = 1024
) (
  input  logic i_clk,
  input  logic i_rst,
  input  logic i_byte_seen,
  input  logic i_idle_run,
  output logic o_idle_expired,
  output logic o_pace_tick
);

  localparam int IW = $clog2(IDLE_LIMIT + 1);
  localparam int PW = $clog2(PACE_PERIOD);

  logic [IW-1:0] idle_cnt;
  logic [PW-1:0] pace_cnt;

  // idle counter, held at the limit once reached
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      idle_cnt <= '0;
    end else if (!i_idle_run || i_byte_seen) begin
      idle_cnt <= '0;
    end else if (idle_cnt != IW'(IDLE_LIMIT)) begin
      idle_cnt <= idle_cnt + 1'b1;
    end
  end

  assign o_idle_expired = (idle_cnt == IW'(IDLE_LIMIT));

  // free running pacing counter
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pace_cnt    <= '0;
      o_pace_tick <= 1'b0;
    end else begin
      o_pace_tick <= (pace_cnt == PW'(PACE_PERIOD - 1));
      if (pace_cnt == PW'(PACE_PERIOD - 1)) begin
        pace_cnt <= '0;
      end else begin
        pace_cnt <= pace_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: frame_tx.sv
`default_nettype none

module frame_tx (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_start,
  input  mhp_pkg::buf_addr_t i_len,
  input  logic               i_wready,
  input  logic [7:0]         i_rdata,
  output mhp_pkg::mem_req_t  o_mem_req,
  output logic [7:0]         o_wdata,
  output logic               o_wvalid,
  output logic               o_done
);
  import mhp_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_ADDR, S_LOAD, S_SEND} state_t;

  state_t     state;
  buf_addr_t  idx;
  logic [7:0] byte_q;

  assign o_mem_req = '{we: 1'b0, addr: idx, wdata: 8'h00};
  assign o_wdata   = byte_q;
  // byte is held in S_SEND until the sink is ready
  assign o_wvalid  = (state == S_SEND) && i_wready;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state  <= S_IDLE;
      idx    <= '0;
      o_done <= 1'b0;
    end else begin
      o_done <= 1'b0;
      case (state)
        S_IDLE: begin
          if (i_start) begin
            idx   <= '0;
            state <= S_ADDR;
          end
        end
        S_ADDR: state <= S_LOAD;
        S_LOAD: state <= S_SEND;
        S_SEND: begin
          if (i_wready) begin
            if (idx == i_len - 1'b1) begin
              o_done <= 1'b1;
              idx    <= '0;
              state  <= S_IDLE;
            end else begin
              idx   <= idx + 1'b1;
              state <= S_ADDR;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (state == S_LOAD) begin
      byte_q <= i_rdata;
    end
  end

endmodule

`default_nettype wire

// File: header_parser.sv
`default_nettype none

module header_parser (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  logic                 i_start,
  input  mhp_pkg::buf_addr_t   i_len,
  input  logic [7:0]           i_rdata,
  output mhp_pkg::mem_req_t    o_mem_req,
  output mhp_pkg::mhp_header_t o_hdr,
  output logic                 o_accept,
  output logic                 o_done
);
  import mhp_pkg::*;

  typedef enum logic [2:0] {S_IDLE, S_ADDR, S_LOAD, S_NEXT, S_CHECK} state_t;

  state_t      state;
  logic [3:0]  idx;
  mhp_header_t hdr_q;
  logic [16:0] echo_need;
  logic        type_ok;
  logic        accept;

  assign o_mem_req = '{we: 1'b0, addr: buf_addr_t'(idx), wdata: 8'h00};
  assign o_hdr     = hdr_q;

  //////////////////////////////
  // acceptance
  //////////////////////////////

  assign echo_need = {1'b0, hdr_q.size} + 17'd7;

  always_comb begin
    case (hdr_q.dtype.ptype)
      TYPE_PING, TYPE_CALC: type_ok = 1'b1;
      TYPE_ECHO:            type_ok = (17'(i_len) >= echo_need);
      default:              type_ok = 1'b0;
    endcase
  end

  assign accept = (i_len >= buf_addr_t'(HDR_LEN)) && !hdr_q.dtype.direction &&
                  !hdr_q.dtype.ptype[TYPE_NOREPLY_BIT] && type_ok;

  //////////////////////////////
  // header walk
  //////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state    <= S_IDLE;
      idx      <= '0;
      o_accept <= 1'b0;
      o_done   <= 1'b0;
    end else begin
      o_done <= 1'b0;
      case (state)
        S_IDLE: begin
          if (i_start) begin
            idx      <= '0;
            o_accept <= 1'b0;
            state    <= S_ADDR;
          end
        end
        S_ADDR: state <= S_LOAD;
        S_LOAD: state <= (idx == 4'(HDR_LEN - 1)) ? S_CHECK : S_NEXT;
        S_NEXT: begin
          idx   <= idx + 1'b1;
          state <= S_ADDR;
        end
        S_CHECK: begin
          o_accept <= accept;
          o_done   <= 1'b1;
          idx      <= '0;
          state    <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // bytes arrive in wire order, so shift them in from the bottom
  always_ff @(posedge i_clk) begin
    if (state == S_LOAD) begin
      hdr_q <= {hdr_q[$bits(mhp_header_t)-9:0], i_rdata};
    end
  end

endmodule

`default_nettype wire

// File: mhp_pkg.sv
`default_nettype none

package mhp_pkg;

  //////////////////////////////
  // buffer
  //////////////////////////////

  localparam int BUF_AW = 11;

  // buffer address, also used for frame lengths
  typedef logic [BUF_AW-1:0] buf_addr_t;

  // one client's access to the buffer, all zeros when idle
  typedef struct packed {
    logic       we;
    buf_addr_t  addr;
    logic [7:0] wdata;
  } mem_req_t;

  //////////////////////////////
  // frame header
  //////////////////////////////

  typedef struct packed {
    logic       direction;  // 0 for requests
    logic [6:0] ptype;
  } dtype_t;

  // fields in wire order, first byte in the top bits
  typedef struct packed {
    logic [15:0]        src;
    logic [15:0]        dst;
    logic [15:0]        size;
    dtype_t             dtype;
    logic [7:0]         operand;
    logic signed [15:0] para1;
    logic signed [15:0] para2;
  } mhp_header_t;

  localparam int HDR_LEN = 12;

  // request types
  localparam logic [6:0] TYPE_PING = 7'h01;
  localparam logic [6:0] TYPE_ECHO = 7'h05;
  localparam logic [6:0] TYPE_CALC = 7'h0D;
  localparam int         TYPE_NOREPLY_BIT = 4;

  // reply type bytes
  localparam logic [7:0] RTYPE_PING = 8'h81;
  localparam logic [7:0] RTYPE_ECHO = 8'h85;
  localparam logic [7:0] RTYPE_CALC = 8'h8E;

  // calc operands
  localparam logic [7:0] OP_ADD = 8'h10;
  localparam logic [7:0] OP_SUB = 8'h20;
  localparam logic [7:0] OP_MUL = 8'h30;

endpackage

`default_nettype wire

// File: mhp_top.sv
`default_nettype none

module mhp_top #(
  parameter int IDLE_LIMIT  = 63,
  parameter int PACE_PERIOD = 1024
) (
  input  logic       i_clk,
  input  logic       i_rst,
  input  logic       i_rready,
  input  logic [7:0] i_rdata,
  output logic       o_rreq,
  input  logic       i_wready,
  output logic [7:0] o_wdata,
  output logic       o_wvalid,
  output logic       o_done
);
  import mhp_pkg::*;

  mem_req_t    rx_req;
  mem_req_t    parse_req;
  mem_req_t    write_req;
  mem_req_t    tx_req;
  logic [7:0]  rdata;
  buf_addr_t   rx_len;
  buf_addr_t   reply_len;
  mhp_header_t hdr;
  logic        byte_seen;
  logic        idle_run;
  logic        idle_expired;
  logic        pace_tick;
  logic        accept;
  logic        rx_start;
  logic        rx_stop;
  logic        parse_start;
  logic        parse_done;
  logic        write_start;
  logic        write_done;
  logic        tx_start;
  logic        tx_done;

  //////////////////////////////
  // datapath
  //////////////////////////////

  frame_buffer u_buffer (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_rx_req   (rx_req),
    .i_parse_req(parse_req),
    .i_write_req(write_req),
    .i_tx_req   (tx_req),
    .o_rdata    (rdata)
  );

  frame_rx u_rx (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_start    (rx_start),
    .i_stop     (rx_stop),
    .i_rready   (i_rready),
    .i_rdata    (i_rdata),
    .o_rreq     (o_rreq),
    .o_byte_seen(byte_seen),
    .o_mem_req  (rx_req),
    .o_len      (rx_len)
  );

  header_parser u_parser (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_start  (parse_start),
    .i_len    (rx_len),
    .i_rdata  (rdata),
    .o_mem_req(parse_req),
    .o_hdr    (hdr),
    .o_accept (accept),
    .o_done   (parse_done)
  );

  reply_writer u_writer (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_start    (write_start),
    .i_hdr      (hdr),
    .o_mem_req  (write_req),
    .o_reply_len(reply_len),
    .o_done     (write_done)
  );

  frame_tx u_tx (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_start  (tx_start),
    .i_len    (reply_len),
    .i_wready (i_wready),
    .i_rdata  (rdata),
    .o_mem_req(tx_req),
    .o_wdata  (o_wdata),
    .o_wvalid (o_wvalid),
    .o_done   (tx_done)
  );

  //////////////////////////////
  // control
  //////////////////////////////

  frame_timer #(
    .IDLE_LIMIT (IDLE_LIMIT),
    .PACE_PERIOD(PACE_PERIOD)
  ) u_timer (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_byte_seen   (byte_seen),
    .i_idle_run    (idle_run),
    .o_idle_expired(idle_expired),
    .o_pace_tick   (pace_tick)
  );

  protocol_fsm u_fsm (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_rready      (i_rready),
    .i_wready      (i_wready),
    .i_idle_expired(idle_expired),
    .i_pace_tick   (pace_tick),
    .i_accept      (accept),
    .i_parse_done  (parse_done),
    .i_write_done  (write_done),
    .i_tx_done     (tx_done),
    .o_rx_start    (rx_start),
    .o_rx_stop     (rx_stop),
    .o_idle_run    (idle_run),
    .o_parse_start (parse_start),
    .o_write_start (write_start),
    .o_tx_start    (tx_start),
    .o_done        (o_done)
  );

endmodule

`default_nettype wire

// File: protocol_fsm.sv
`default_nettype none

module protocol_fsm (
  input  logic i_clk,
  input  logic i_rst,
  input  logic i_rready,
  input  logic i_wready,
  input  logic i_idle_expired,
  input  logic i_pace_tick,
  input  logic i_accept,
  input  logic i_parse_done,
  input  logic i_write_done,
  input  logic i_tx_done,
  output logic o_rx_start,
  output logic o_rx_stop,
  output logic o_idle_run,
  output logic o_parse_start,
  output logic o_write_start,
  output logic o_tx_start,
  output logic o_done
);

  typedef enum logic [2:0] {
    S_IDLE, S_RX, S_PARSE, S_WRITE, S_PACE, S_TX, S_DROP
  } state_t;

  state_t state;

  assign o_idle_run = (state == S_RX);
  // lands in the cycle after the last transmitted byte
  assign o_done     = (state == S_TX && i_tx_done) || (state == S_DROP);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state         <= S_IDLE;
      o_rx_start    <= 1'b0;
      o_rx_stop     <= 1'b0;
      o_parse_start <= 1'b0;
      o_write_start <= 1'b0;
      o_tx_start    <= 1'b0;
    end else begin
      o_rx_start    <= 1'b0;
      o_rx_stop     <= 1'b0;
      o_parse_start <= 1'b0;
      o_write_start <= 1'b0;
      o_tx_start    <= 1'b0;
      case (state)
        S_IDLE: begin
          if (i_rready) begin
            o_rx_start <= 1'b1;
            state      <= S_RX;
          end
        end
        // frame ends after the line has been quiet long enough
        S_RX: begin
          if (i_idle_expired) begin
            o_rx_stop     <= 1'b1;
            o_parse_start <= 1'b1;
            state         <= S_PARSE;
          end
        end
        S_PARSE: begin
          if (i_parse_done) begin
            if (i_accept) begin
              o_write_start <= 1'b1;
              state         <= S_WRITE;
            end else begin
              state <= S_DROP;
            end
          end
        end
        S_WRITE: begin
          if (i_write_done) begin
            state <= S_PACE;
          end
        end
        // replies only go out on a pacing tick
        S_PACE: begin
          if (i_pace_tick && i_wready) begin
            o_tx_start <= 1'b1;
            state      <= S_TX;
          end
        end
        S_TX: begin
          if (i_tx_done) begin
            state <= S_IDLE;
          end
        end
        S_DROP:  state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: reply_writer.sv
`default_nettype none

module reply_writer (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  logic                 i_start,
  input  mhp_pkg::mhp_header_t i_hdr,
  output mhp_pkg::mem_req_t    o_mem_req,
  output mhp_pkg::buf_addr_t   o_reply_len,
  output logic                 o_done
);
  import mhp_pkg::*;

  typedef enum logic [2:0] {S_IDLE, S_CALC, S_SET, S_WRITE, S_DONE} state_t;

  state_t            state;
  logic [3:0]        idx;
  logic signed [15:0] result;
  logic              is_echo;
  logic              is_calc;
  logic [3:0]        last_idx;
  logic [7:0]        rtype;
  buf_addr_t         reply_len;
  logic [7:0]        reply_byte;

  assign is_echo = (i_hdr.dtype.ptype == TYPE_ECHO);
  assign is_calc = (i_hdr.dtype.ptype == TYPE_CALC);

  //////////////////////////////
  // reply layout
  //////////////////////////////

  // echo keeps the payload, so only its first seven bytes are rewritten
  always_comb begin
    if (is_echo) begin
      last_idx  = 4'd6;
      rtype     = RTYPE_ECHO;
      reply_len = buf_addr_t'(i_hdr.size + 16'd7);
    end else if (is_calc) begin
      last_idx  = 4'd8;
      rtype     = RTYPE_CALC;
      reply_len = buf_addr_t'(9);
    end else begin
      last_idx  = 4'd9;
      rtype     = RTYPE_PING;
      reply_len = buf_addr_t'(10);
    end
  end

  always_comb begin
    case (idx)
      4'd0:    reply_byte = i_hdr.dst[15:8];
      4'd1:    reply_byte = i_hdr.dst[7:0];
      4'd2:    reply_byte = i_hdr.src[15:8];
      4'd3:    reply_byte = i_hdr.src[7:0];
      4'd4:    reply_byte = is_echo ? i_hdr.size[15:8] : 8'h00;
      4'd5:    reply_byte = is_echo ? i_hdr.size[7:0] : (is_calc ? 8'h02 : 8'h01);
      4'd6:    reply_byte = rtype;
      4'd7:    reply_byte = is_calc ? result[15:8] : 8'h00;
      4'd8:    reply_byte = is_calc ? result[7:0] : 8'h00;
      default: reply_byte = 8'h00;
    endcase
  end

  // address and data settle one cycle before the write strobe
  assign o_mem_req = (state == S_SET || state == S_WRITE) ?
                     '{we: (state == S_WRITE), addr: buf_addr_t'(idx), wdata: reply_byte} :
                     '0;

  //////////////////////////////
  // sequencing
  //////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state       <= S_IDLE;
      idx         <= '0;
      o_reply_len <= '0;
      o_done      <= 1'b0;
    end else begin
      o_done <= 1'b0;
      case (state)
        S_IDLE: begin
          if (i_start) begin
            idx   <= '0;
            state <= S_CALC;
          end
        end
        S_CALC:  state <= S_SET;
        S_SET:   state <= S_WRITE;
        S_WRITE: begin
          if (idx == last_idx) begin
            state <= S_DONE;
          end else begin
            idx   <= idx + 1'b1;
            state <= S_SET;
          end
        end
        S_DONE: begin
          o_reply_len <= reply_len;
          o_done      <= 1'b1;
          idx         <= '0;
          state       <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // low 16 bits of the signed result
  always_ff @(posedge i_clk) begin
    if (state == S_CALC) begin
      case (i_hdr.operand)
        OP_ADD:  result <= i_hdr.para1 + i_hdr.para2;
        OP_SUB:  result <= i_hdr.para1 - i_hdr.para2;
        OP_MUL:  result <= i_hdr.para1 * i_hdr.para2;
        default: result <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: tb_clock.sv
`default_nettype none

module tb_clock (
  output logic o_clk,
  output logic o_rst
);
  timeunit 1ns;
  timeprecision 100ps;

  // 4 ns period
  initial begin
    o_clk = 1'b0;
    forever begin
      #2 o_clk = ~o_clk;
    end
  end

  // high for two rising edges, released just after the second
  initial begin
    o_rst = 1'b1;
    repeat (2) @(posedge o_clk);
    #1;
    o_rst = 1'b0;
  end

endmodule

`default_nettype wire

// File: tb_mhp.sv
`default_nettype none

module tb_mhp;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int PACE_PERIOD = 64;
  localparam int SEED        = 79840;
  // ten frames of a few hundred cycles each stay well below this even with stalls
  localparam int MAX_CYCLES  = 20000;

  logic       clk;
  logic       rst;
  logic       rready;
  logic [7:0] rdata;
  logic       rreq;
  logic       wready;
  logic [7:0] wdata;
  logic       wvalid;
  logic       done;

  // frame under test and its expected reply
  logic [7:0] req[$];
  logic [7:0] exp_reply[$];
  // bytes handed to the receive FIFO and bytes seen on the transmit port
  logic [7:0] fifo_q[$];
  logic [7:0] got[$];
  int         stall_q[$];
  logic       stall_on = 1'b0;

  int cycle_cnt = 0;
  int done_cnt = 0;
  int done_cycle = 0;
  int last_wvalid_cycle = 0;
  int rx_errors = 0;
  int tx_errors = 0;
  int check_errors = 0;
  int tests_run = 0;
  int tests_failed = 0;

  tb_clock u_clock (
    .o_clk(clk),
    .o_rst(rst)
  );

  mhp_top #(
    .IDLE_LIMIT (63),
    .PACE_PERIOD(PACE_PERIOD)
  ) dut (
    .i_clk   (clk),
    .i_rst   (rst),
    .i_rready(rready),
    .i_rdata (rdata),
    .o_rreq  (rreq),
    .i_wready(wready),
    .o_wdata (wdata),
    .o_wvalid(wvalid),
    .o_done  (done)
  );

  //////////////////////////////
  // port models
  //////////////////////////////

  // fifo byte shows up on i_rdata in the cycle after o_rreq
  initial begin : fifo_model
    logic pop_due;
    int   rd_ptr;
    rd_ptr = 0;
    rready = 1'b0;
    rdata  = 8'h00;
    forever begin
      @(negedge clk);
      pop_due = rreq;
      @(posedge clk);
      #1;
      if (pop_due === 1'b1) begin
        if (rd_ptr >= fifo_q.size()) begin
          $display("receive FIFO was read while empty at %0d ns", $time);
          rx_errors++;
        end else begin
          rdata = fifo_q[rd_ptr];
          rd_ptr++;
        end
      end
      rready = (rd_ptr < fifo_q.size());
    end
  end

  // alternating low and high stretches while a stall test runs
  initial begin : wready_driver
    int left;
    int idx;
    left   = 0;
    idx    = 0;
    wready = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      if (!stall_on) begin
        wready = 1'b1;
        left   = 0;
        idx    = 0;
      end else if (left > 0) begin
        left--;
      end else if (idx < stall_q.size()) begin
        wready = ~wready;
        left   = stall_q[idx];
        idx++;
      end else begin
        wready = 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  always @(negedge clk) begin
    if (wvalid === 1'b1) begin
      if (wready !== 1'b1) begin
        $display("CHECK FAILED at %0d ns: o_wvalid while i_wready is low", $time);
        tx_errors++;
      end
      got.push_back(wdata);
      last_wvalid_cycle = cycle_cnt;
    end
    if (done === 1'b1) begin
      done_cnt++;
      done_cycle = cycle_cnt;
    end
  end

  initial begin : watchdog
    wait (cycle_cnt >= MAX_CYCLES);
    $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  function automatic int error_total();
    return rx_errors + tx_errors + check_errors;
  endfunction

  // 16-bit field sent MSB first
  task automatic push_word(input logic [15:0] w);
    req.push_back(w[15:8]);
    req.push_back(w[7:0]);
  endtask

  task automatic build_header(input logic [15:0] src, input logic [15:0] dst,
                              input logic [15:0] size, input logic [7:0] dtype,
                              input logic [7:0] operand, input logic [15:0] p1,
                              input logic [15:0] p2);
    req.delete();
    push_word(src);
    push_word(dst);
    push_word(size);
    req.push_back(dtype);
    req.push_back(operand);
    push_word(p1);
    push_word(p2);
  endtask

  // every reply opens with the request's dst and then its src
  task automatic swapped_addresses();
    exp_reply.delete();
    exp_reply.push_back(req[2]);
    exp_reply.push_back(req[3]);
    exp_reply.push_back(req[0]);
    exp_reply.push_back(req[1]);
  endtask

  task automatic run_frame(input string name, input bit replies);
    int errs_before;
    int done_before;
    int base;
    int n;
    errs_before = error_total();
    done_before = done_cnt;
    base        = got.size();
    @(negedge clk);
    foreach (req[i]) begin
      fifo_q.push_back(req[i]);
    end
    while (done_cnt == done_before) begin
      @(posedge clk);
    end
    n = got.size() - base;
    if (replies) begin
      if (n != exp_reply.size()) begin
        $display("CHECK FAILED at %0d ns: %s reply has %0d bytes, expected %0d",
                 $time, name, n, exp_reply.size());
        check_errors++;
      end else begin
        for (int i = 0; i < n; i++) begin
          if (got[base + i] !== exp_reply[i]) begin
            $display("CHECK FAILED at %0d ns: %s byte %0d is %02h, expected %02h",
                     $time, name, i, got[base + i], exp_reply[i]);
            check_errors++;
          end
        end
        if (done_cycle != last_wvalid_cycle + 1) begin
          $display("CHECK FAILED at %0d ns: %s done pulse not right after last byte",
                   $time, name);
          check_errors++;
        end
      end
    end else if (n != 0) begin
      $display("CHECK FAILED at %0d ns: %s dropped frame sent %0d bytes", $time, name, n);
      check_errors++;
    end
    tests_run++;
    if (error_total() == errs_before) begin
      $display("%-14s passed", name);
    end else begin
      tests_failed++;
      $display("%-14s failed", name);
    end
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////

  task automatic ping_reply();
    build_header(16'($urandom), 16'($urandom), 16'($urandom), 8'h01, 8'($urandom),
                 16'($urandom), 16'($urandom));
    swapped_addresses();
    exp_reply.push_back(8'h00);
    exp_reply.push_back(8'h01);
    exp_reply.push_back(8'h81);
    for (int i = 0; i < 3; i++) begin
      exp_reply.push_back(8'h00);
    end
    run_frame("ping", 1'b1);
  endtask

  task automatic echo_reply(input string name, input bit stall);
    int          n;
    logic [15:0] size;
    n    = 5 + int'($urandom % 36);
    // size covers everything received after the first seven bytes
    size = 16'(12 + n - 7);
    build_header(16'($urandom), 16'($urandom), size, 8'h05, 8'($urandom),
                 16'($urandom), 16'($urandom));
    for (int i = 0; i < n; i++) begin
      req.push_back(8'($urandom));
    end
    swapped_addresses();
    exp_reply.push_back(size[15:8]);
    exp_reply.push_back(size[7:0]);
    exp_reply.push_back(8'h85);
    for (int i = 7; i < req.size(); i++) begin
      exp_reply.push_back(req[i]);
    end
    stall_q.delete();
    if (stall) begin
      for (int i = 0; i < 200; i++) begin
        stall_q.push_back(int'($urandom % 6));
      end
    end
    stall_on = stall;
    run_frame(name, 1'b1);
    stall_on = 1'b0;
  endtask

  task automatic calc_reply(input string name, input logic [7:0] op);
    shortint     a;
    shortint     b;
    int          full;
    logic [15:0] r;
    a = shortint'($urandom);
    b = shortint'($urandom);
    // only the low 16 bits of the exact signed value go back
    case (op)
      8'h10:   full = int'(a) + int'(b);
      8'h20:   full = int'(a) - int'(b);
      8'h30:   full = int'(a) * int'(b);
      default: full = 0;
    endcase
    r = full[15:0];
    build_header(16'($urandom), 16'($urandom), 16'($urandom), 8'h0D, op, a, b);
    swapped_addresses();
    exp_reply.push_back(8'h00);
    exp_reply.push_back(8'h02);
    exp_reply.push_back(8'h8E);
    exp_reply.push_back(r[15:8]);
    exp_reply.push_back(r[7:0]);
    run_frame(name, 1'b1);
  endtask

  task automatic dropped_frames();
    // no-reply bit of the type set
    build_header(16'($urandom), 16'($urandom), 16'h0000, 8'h11, 8'h00, 16'h0000, 16'h0000);
    run_frame("drop_noreply", 1'b0);
    // a ping in the reply direction
    build_header(16'($urandom), 16'($urandom), 16'h0000, 8'h81, 8'h00, 16'h0000, 16'h0000);
    run_frame("drop_reply", 1'b0);
    // header cut short after eight bytes
    build_header(16'($urandom), 16'($urandom), 16'h0000, 8'h01, 8'h00, 16'h0000, 16'h0000);
    while (req.size() > 8) begin
      void'(req.pop_back());
    end
    run_frame("drop_short", 1'b0);
  endtask

  initial begin : main
    void'($urandom(SEED));
    wait (rst === 1'b0);
    @(posedge clk);
    ping_reply();
    echo_reply("echo", 1'b0);
    calc_reply("calc_add", 8'h10);
    calc_reply("calc_sub", 8'h20);
    calc_reply("calc_mul", 8'h30);
    calc_reply("calc_other", 8'h40 + 8'($urandom % 16));
    dropped_frames();
    echo_reply("echo_stall", 1'b1);
    $display("tests run %0d, tests failed %0d, errors %0d",
             tests_run, tests_failed, error_total());
    if (tests_failed == 0 && error_total() == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire
